/* include/cpu_settings.svh */
// widths and memory depths for the cpu core
// word, address and register select widths
// instruction and data memory depths in words

`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// register and memory word
`define CPU_DATA_W 32

// program counter and byte addresses
`define CPU_PC_W 16

// register select
`define CPU_REG_SEL_W 4

// register file size
`define CPU_NUM_REGS 16

// memory depths in words
`define CPU_IM_WORDS 256
`define CPU_DM_WORDS 256

`endif

/* design/cpu_pkg.sv */
// shared types for the cpu core
// opcode and alu enums, control bundle
// stage register structs, redirect and writeback structs

`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0]    word_t;
    typedef logic [`CPU_PC_W-1:0]      pc_t;
    typedef logic [`CPU_REG_SEL_W-1:0] reg_sel_t;

    typedef enum logic [7:0] {
        OP_NOP  = 8'h00,
        OP_ADD  = 8'h10,
        OP_SUB  = 8'h11,
        OP_AND  = 8'h12,
        OP_OR   = 8'h13,
        OP_ADDI = 8'h18,
        OP_LD   = 8'h20,
        OP_ST   = 8'h21,
        OP_BEQ  = 8'h30,
        OP_BNE  = 8'h31,
        OP_JMP  = 8'h38
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_PASS_B
    } alu_fn_t;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JMP
    } br_kind_t;

    typedef struct packed {
        alu_fn_t  alu_fn;
        logic     use_imm;    // b operand from immediate
        logic     reg_wrt;
        logic     mem_wrt;
        logic     mem_rd;
        br_kind_t branch;
        logic     sets_flags;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t instr;
        pc_t   pc;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        word_t    op_a;
        word_t    op_b;
        word_t    st_data;
        word_t    imm;
        reg_sel_t dest;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        logic     reg_wrt;
        logic     mem_wrt;
        logic     mem_rd;
        word_t    result;     // alu value or memory address
        word_t    st_data;
        reg_sel_t dest;
    } ex_mem_t;

    typedef struct packed {
        logic taken;
        pc_t  target;
    } redirect_t;

    typedef struct packed {
        logic     en;
        reg_sel_t sel;
        word_t    data;
    } reg_wr_t;

endpackage

`default_nettype wire

/* design/cpu_fetch.sv */
// fetch stage
// program counter with stall hold and redirect load
// instruction memory with program load port
// fetch register with flush on redirect

`default_nettype none
`timescale 1ns/1ps

`include "cpu_settings.svh"

module cpu_fetch import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      run,
    input  logic      stall,
    input  redirect_t redirect,
    input  logic      prog_wrt_en,
    input  pc_t       prog_addr,
    input  word_t     prog_data,
    output if_id_t    if_id
);

    localparam int IM_AW = $clog2(`CPU_IM_WORDS);

    word_t imem [`CPU_IM_WORDS];

    pc_t   pc_q;
    logic  valid_q;
    word_t instr_q;
    pc_t   instr_pc_q;
    logic  step;          // normal advance this cycle

    assign step = run && !stall && !redirect.taken;

    // pc and fetch valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q    <= '0;
            valid_q <= 1'b0;
        end else if (run) begin
            if (redirect.taken) begin
                pc_q    <= redirect.target;
                valid_q <= 1'b0;     // wrong-path word dropped
            end else if (!stall) begin
                pc_q    <= pc_q + pc_t'(4);
                valid_q <= 1'b1;
            end
        end
    end

    // memory port, program write wins over the read
    always_ff @(posedge clk) begin
        if (prog_wrt_en) begin
            imem[prog_addr[IM_AW+1:2]] <= prog_data;
        end else if (step) begin
            instr_q    <= imem[pc_q[IM_AW+1:2]];
            instr_pc_q <= pc_q;
        end
    end

    assign if_id = '{valid: valid_q, instr: instr_q, pc: instr_pc_q};

    // program loads only happen while the core is frozen
    a_no_load_while_run: assert property (
        @(posedge clk) disable iff (!rst_n) !(prog_wrt_en && run)
    ) else $error("program write while run is high");

endmodule

`default_nettype wire

/* design/cpu_decode.sv */
// decode stage
// opcode to control mapping, register file with write-first read
// read-after-write stall against execute and result
// decode-to-execute register

`default_nettype none
`timescale 1ns/1ps

`include "cpu_settings.svh"

module cpu_decode import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      run,
    input  if_id_t    if_id,
    input  ex_mem_t   ex_mem,
    input  redirect_t redirect,
    input  reg_wr_t   reg_wr,
    output logic      stall,
    output id_ex_t    id_ex
);

    word_t    regs [`CPU_NUM_REGS];
    opcode_t  op;
    reg_sel_t rd, rs, rt;
    ctrl_t    ctrl;
    logic     reads_rs, reads_rt, reads_rd;
    id_ex_t   nxt;
    id_ex_t   pay_q;
    logic     valid_q;

    assign op = opcode_t'(if_id.instr[31:24]);
    assign rd = if_id.instr[23:20];
    assign rs = if_id.instr[19:16];
    assign rt = if_id.instr[15:12];

    function automatic word_t rf_read(reg_sel_t sel);
        word_t val;
        if (sel == '0)
            val = '0;
        else if (reg_wr.en && reg_wr.sel == sel)
            val = reg_wr.data;   // same-cycle write seen
        else
            val = regs[sel];
        return val;
    endfunction

    // older instruction still to write sel
    function automatic logic pending(reg_sel_t sel);
        return (id_ex.valid && id_ex.ctrl.reg_wrt && id_ex.dest == sel) ||
               (ex_mem.valid && ex_mem.reg_wrt && ex_mem.dest == sel);
    endfunction

    //////////////////////////////////////////////////
    // control decode
    //////////////////////////////////////////////////
    always_comb begin
        ctrl        = '0;
        ctrl.alu_fn = ALU_PASS_B;
        ctrl.branch = BR_NONE;
        reads_rs    = 1'b0;
        reads_rt    = 1'b0;
        reads_rd    = 1'b0;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR: begin
                ctrl.alu_fn     = (op == OP_ADD) ? ALU_ADD :
                                  (op == OP_SUB) ? ALU_SUB :
                                  (op == OP_AND) ? ALU_AND : ALU_OR;
                ctrl.reg_wrt    = 1'b1;
                ctrl.sets_flags = 1'b1;
                reads_rs        = 1'b1;
                reads_rt        = 1'b1;
            end
            OP_ADDI: begin
                ctrl.alu_fn     = ALU_ADD;
                ctrl.use_imm    = 1'b1;
                ctrl.reg_wrt    = 1'b1;
                ctrl.sets_flags = 1'b1;
                reads_rs        = 1'b1;
            end
            OP_LD, OP_ST: begin
                ctrl.alu_fn  = ALU_ADD;       // address is rs + imm
                ctrl.use_imm = 1'b1;
                ctrl.reg_wrt = (op == OP_LD);
                ctrl.mem_rd  = (op == OP_LD);
                ctrl.mem_wrt = (op == OP_ST);
                reads_rs     = 1'b1;
                reads_rd     = (op == OP_ST); // store data
            end
            OP_BEQ:  ctrl.branch = BR_EQ;
            OP_BNE:  ctrl.branch = BR_NE;
            OP_JMP:  ctrl.branch = BR_JMP;
            default: ;                        // nop
        endcase
        if (ctrl.branch != BR_NONE)
            ctrl.use_imm = 1'b1;              // target passes through alu
    end

    always_comb begin
        stall = if_id.valid && ((reads_rs && pending(rs)) ||
                                (reads_rt && pending(rt)) ||
                                (reads_rd && pending(rd)));
    end

    always_comb begin
        nxt.valid   = if_id.valid && !stall && !redirect.taken;
        nxt.ctrl    = ctrl;
        nxt.op_a    = rf_read(rs);
        nxt.op_b    = rf_read(rt);
        nxt.st_data = rf_read(rd);
        nxt.imm     = {16'b0, if_id.instr[15:0]};
        nxt.dest    = rd;
    end

    //////////////////////////////////////////////////
    // register file and stage register
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++)
                regs[i] <= '0;
        end else if (reg_wr.en && reg_wr.sel != '0) begin
            regs[reg_wr.sel] <= reg_wr.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            valid_q <= 1'b0;
        else if (run)
            valid_q <= nxt.valid;   // bubble on stall or flush
    end

    always_ff @(posedge clk) begin
        if (run)
            pay_q <= nxt;
    end

    always_comb begin
        id_ex       = pay_q;
        id_ex.valid = valid_q;
    end

    a_no_r0_write: assert property (
        @(posedge clk) disable iff (!rst_n) reg_wr.en |-> reg_wr.sel != '0
    ) else $error("register write targets r0");

endmodule

`default_nettype wire

/* design/cpu_execute.sv */
// execute stage
// alu on operand a and operand b or immediate
// zero flag register, branch resolution
// execute-to-result register

`default_nettype none
`timescale 1ns/1ps

`include "cpu_settings.svh"

module cpu_execute import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      run,
    input  id_ex_t    id_ex,
    output redirect_t redirect,
    output ex_mem_t   ex_mem
);

    word_t   alu_b;
    word_t   alu_y;
    logic    zf_q;
    logic    cond;
    ex_mem_t nxt;
    ex_mem_t pay_q;
    logic    valid_q;

    assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : id_ex.op_b;

    always_comb begin
        case (id_ex.ctrl.alu_fn)
            ALU_ADD: alu_y = id_ex.op_a + alu_b;
            ALU_SUB: alu_y = id_ex.op_a - alu_b;
            ALU_AND: alu_y = id_ex.op_a & alu_b;
            ALU_OR:  alu_y = id_ex.op_a | alu_b;
            default: alu_y = alu_b;            // pass b
        endcase
    end

    // flag from the last flag-setting instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            zf_q <= 1'b0;
        end else if (run && id_ex.valid && id_ex.ctrl.sets_flags) begin
            zf_q <= (alu_y == '0);
        end
    end

    //////////////////////////////////////////////////
    // branch resolution
    //////////////////////////////////////////////////
    always_comb begin
        case (id_ex.ctrl.branch)
            BR_EQ:   cond = zf_q;
            BR_NE:   cond = !zf_q;
            BR_JMP:  cond = 1'b1;
            default: cond = 1'b0;
        endcase
        redirect.taken  = id_ex.valid && cond;
        redirect.target = alu_y[`CPU_PC_W-1:0];   // immediate via pass b
    end

    always_comb begin
        nxt.valid   = id_ex.valid;
        nxt.reg_wrt = id_ex.ctrl.reg_wrt;
        nxt.mem_wrt = id_ex.ctrl.mem_wrt;
        nxt.mem_rd  = id_ex.ctrl.mem_rd;
        nxt.result  = alu_y;
        nxt.st_data = id_ex.st_data;
        nxt.dest    = id_ex.dest;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            valid_q <= 1'b0;
        else if (run)
            valid_q <= nxt.valid;
    end

    always_ff @(posedge clk) begin
        if (run)
            pay_q <= nxt;
    end

    always_comb begin
        ex_mem       = pay_q;
        ex_mem.valid = valid_q;
    end

    a_target_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect.taken |-> redirect.target[1:0] == 2'b00
    ) else $error("branch target not word aligned");

endmodule

`default_nettype wire

/* design/cpu_result.sv */
// result stage
// data memory with async read and clocked write
// store port toward the top level
// writeback select between load data and alu result

`default_nettype none
`timescale 1ns/1ps

`include "cpu_settings.svh"

module cpu_result import cpu_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  ex_mem_t ex_mem,
    output reg_wr_t reg_wr,
    output logic    st_en,
    output pc_t     st_addr,
    output word_t   st_data
);

    localparam int DM_AW = $clog2(`CPU_DM_WORDS);

    word_t dmem [`CPU_DM_WORDS];

    logic [DM_AW-1:0] dm_idx;
    logic             st_fire;
    word_t            ld_data;

    assign dm_idx  = ex_mem.result[DM_AW+1:2];   // word index
    assign st_fire = ex_mem.valid && ex_mem.mem_wrt;
    assign ld_data = dmem[dm_idx];

    always_ff @(posedge clk) begin
        if (st_fire)
            dmem[dm_idx] <= ex_mem.st_data;
    end

    // store port
    assign st_en   = st_fire;
    assign st_addr = ex_mem.result[`CPU_PC_W-1:0];
    assign st_data = ex_mem.st_data;

    // writeback lands at the next edge
    always_comb begin
        reg_wr.en   = ex_mem.valid && ex_mem.reg_wrt;
        reg_wr.sel  = ex_mem.dest;
        reg_wr.data = ex_mem.mem_rd ? ld_data : ex_mem.result;
    end

    // rs + imm from decode and execute must land inside data memory
    a_dm_addr_ok: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ex_mem.valid && (ex_mem.mem_wrt || ex_mem.mem_rd)) |->
            (ex_mem.result[1:0] == 2'b00 && ex_mem.result < (`CPU_DM_WORDS * 4))
    ) else $error("data address out of range or unaligned");

endmodule

`default_nettype wire

/* design/cpu_core.sv */
// top level of the cpu core
// fetch, decode, execute and result stages
// program load port in, store port out

`default_nettype none
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  run,          // low freezes the pipeline
    input  logic  prog_wrt_en,
    input  pc_t   prog_addr,
    input  word_t prog_data,
    output logic  st_en,
    output pc_t   st_addr,
    output word_t st_data
);

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    redirect_t redirect;
    reg_wr_t   reg_wr;
    logic      stall;

    cpu_fetch u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .stall       (stall),
        .redirect    (redirect),
        .prog_wrt_en (prog_wrt_en),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .if_id       (if_id)
    );

    cpu_decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .run      (run),
        .if_id    (if_id),
        .ex_mem   (ex_mem),     // hazard check
        .redirect (redirect),   // flush
        .reg_wr   (reg_wr),
        .stall    (stall),
        .id_ex    (id_ex)
    );

    cpu_execute u_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .run      (run),
        .id_ex    (id_ex),
        .redirect (redirect),
        .ex_mem   (ex_mem)
    );

    cpu_result u_result (
        .clk     (clk),
        .rst_n   (rst_n),
        .ex_mem  (ex_mem),
        .reg_wr  (reg_wr),
        .st_en   (st_en),
        .st_addr (st_addr),
        .st_data (st_data)
    );

endmodule

`default_nettype wire

/* test/cpu_tb.sv */
// testbench for the cpu core
// clock, reset and program load from the test data file
// store port checking against the expected store list
// cycle limit for the whole run

`default_nettype none
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

    logic  clk;
    logic  rst_n;
    logic  run;
    logic  prog_wrt_en;
    pc_t   prog_addr;
    word_t prog_data;
    logic  st_en;
    pc_t   st_addr;
    word_t st_data;

    pc_t   prog_addr_q [$];
    word_t prog_word_q [$];
    pc_t   exp_addr_q [$];
    word_t exp_data_q [$];

    int errors    = 0;
    int n_seen    = 0;      // stores observed so far
    int cycle_cnt = 0;

    cpu_core UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .prog_wrt_en (prog_wrt_en),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .st_en       (st_en),
        .st_addr     (st_addr),
        .st_data     (st_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic check_value(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // one program word through the load strobe
    task automatic write_prog_word(input pc_t addr, input word_t data);
        @(posedge clk);
        prog_wrt_en <= 1'b1;
        prog_addr   <= addr;
        prog_data   <= data;
        @(posedge clk);
        prog_wrt_en <= 1'b0;
    endtask

    //////////////////////////////////////////////////
    // store monitor sampled mid-cycle
    //////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rst_n) begin
            if (!run) begin
                check_value("st_en during load", word_t'(st_en), '0);
            end else if (st_en) begin
                if (n_seen < exp_addr_q.size()) begin
                    check_value("store address", word_t'(st_addr), word_t'(exp_addr_q[n_seen]));
                    check_value("store data", st_data, exp_data_q[n_seen]);
                end else begin
                    errors++;
                    $display("t=%0t: extra store to %h with data %h after the expected list",
                             $time, st_addr, st_data);
                end
                n_seen++;
            end
        end
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin
        int          fd;
        int          rc;
        int          n_fields;
        string       line;
        logic [7:0]  tag;
        word_t       a_val;
        word_t       d_val;
        int unsigned gap;
        int          limit;

        void'($urandom(55730));
        rst_n       = 1'b0;
        run         = 1'b0;
        prog_wrt_en = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;

        fd = $fopen("test/cpu_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the test data file test/cpu_testdata.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc   = $fgets(line, fd);
                if (rc > 0) begin
                    n_fields = $sscanf(line, "%c %h %h", tag, a_val, d_val);
                    if (n_fields == 3 && tag == "P") begin
                        prog_addr_q.push_back(a_val[15:0]);
                        prog_word_q.push_back(d_val);
                    end else if (n_fields == 3 && tag == "S") begin
                        exp_addr_q.push_back(a_val[15:0]);
                        exp_data_q.push_back(d_val);
                    end
                end
            end
            $fclose(fd);
        end

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // load with run low and random idle gaps between words
        foreach (prog_addr_q[i]) begin
            write_prog_word(prog_addr_q[i], prog_word_q[i]);
            gap = $urandom % 4;
            repeat (gap) @(posedge clk);
        end

        limit = 40 * prog_addr_q.size() + 200;
        @(posedge clk);
        run <= 1'b1;

        // keep watching up to the limit so late extra stores show up
        while (cycle_cnt < limit) @(negedge clk);

        if (n_seen < exp_addr_q.size()) begin
            $display("timeout after %0d cycles: the stores did not all arrive, %0d missing",
                     limit, exp_addr_q.size() - n_seen);
            errors += exp_addr_q.size() - n_seen;
        end

        $display("errors: %0d, stores seen: %0d, stores expected: %0d",
                 errors, n_seen, exp_addr_q.size());
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
design/cpu_pkg.sv
design/cpu_fetch.sv
design/cpu_decode.sv
design/cpu_execute.sv
design/cpu_result.sv
design/cpu_core.sv
test/cpu_tb.sv

/* Makefile */
# Verilator build, run and lint for the cpu core
# any variable below can be overridden on the command line

VERILATOR  ?= verilator
TOP        ?= cpu_tb
LINT_TOP   ?= cpu_core
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build sim lint clean

all: sim

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "sim passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/cpu_testdata.txt */
# P lines: program byte address, instruction word, both hex
# S lines: expected store address, store data, both hex, in arrival order
P 0000 18100005  # addi r1, r0, 5
P 0004 18200003  # addi r2, r0, 3
P 0008 10312000  # add  r3, r1, r2
P 000C 11412000  # sub  r4, r1, r2
P 0010 12512000  # and  r5, r1, r2
P 0014 13612000  # or   r6, r1, r2
P 0018 21300040  # st   r3, [r0+40]
P 001C 21400044  # st   r4, [r0+44]
P 0020 21500048  # st   r5, [r0+48]
P 0024 2160004C  # st   r6, [r0+4C]
P 0028 18811000  # addi r8, r1, 1000  chain start
P 002C 21800050  # st   r8, [r0+50]
P 0030 10988000  # add  r9, r8, r8
P 0034 21900054  # st   r9, [r0+54]
P 0038 11A91000  # sub  r10, r9, r1
P 003C 21A00058  # st   r10, [r0+58]
P 0040 18C00080  # addi r12, r0, 80
P 0044 21AC0004  # st   r10, [r12+4]
P 0048 20DC0004  # ld   r13, [r12+4]
P 004C 20E00040  # ld   r14, [r0+40]
P 0050 10DDE000  # add  r13, r13, r14
P 0054 21D0005C  # st   r13, [r0+5C]
P 0058 11F11000  # sub  r15, r1, r1  zero flag set
P 005C 31000068  # bne  68  not taken
P 0060 21100060  # st   r1, [r0+60]
P 0064 3000006C  # beq  6C  taken
P 0068 21200064  # st   r2, [r0+64]  wrong path
P 006C 18F00001  # addi r15, r0, 1  zero flag clear
P 0070 3000007C  # beq  7C  not taken
P 0074 21F00068  # st   r15, [r0+68]
P 0078 31000080  # bne  80  taken
P 007C 2120006C  # st   r2, [r0+6C]  wrong path
P 0080 38000088  # jmp  88
P 0084 21100070  # st   r1, [r0+70]  wrong path
P 0088 21300074  # st   r3, [r0+74]
P 008C 3800008C  # jmp  8C  loop forever
S 0040 00000008
S 0044 00000002
S 0048 00000001
S 004C 00000007
S 0050 00001005
S 0054 0000200A
S 0058 00002005
S 0084 00002005
S 005C 0000200D
S 0060 00000005
S 0068 00000001
S 0074 00000008
